// ==== list.f ====
+incdir+source
source/kronos_types.sv
source/kronos_imm_decode.sv
source/kronos_agu.sv
source/kronos_data_mem.sv
source/kronos_lsu_ctrl.sv
source/kronos_lsu_regs.sv
source/kronos_lsu_top.sv
testbench/kronos_lsu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module kronos_lsu_tb -f list.f -o kronos_lsu_tb

./obj_dir/kronos_lsu_tb > sim.log
cat sim.log

if grep -q "^TESTS PASSED$" sim.log; then
  exit 0
fi
exit 1

// ==== source/kronos_agu.sv ====
// Address adder with misalignment detect
// Catch enables are runtime inputs, a disabled catch never flags
`timescale 1ns/1ns

module kronos_agu (
  input  logic [31:0] instr,
  input  logic [31:0] base,
  input  logic [31:0] offset,
  input  logic        catch_jmp,
  input  logic        catch_ldst,
  output logic [31:0] addr,
  output logic        misaligned_jmp,
  output logic        misaligned_ldst
);

  import kronos_types::*;

  opcode_e     op;
  size_e       size;
  logic [31:0] sum;
  logic        is_jmp;
  logic        is_ldst;
  logic        ldst_off;

  assign op   = opcode_e'(instr[6:2]);
  assign size = size_e'(instr[13:12]);

  // ==================================================
  // Adder
  // ==================================================

  assign sum = base + offset;

  // JALR target drops bit 0
  assign addr = {sum[31:1], sum[0] & (op != INSTR_JALR)};

  // ==================================================
  // Misalignment
  // ==================================================

  assign is_jmp  = (op == INSTR_JAL) || (op == INSTR_JALR) || (op == INSTR_BR);
  assign is_ldst = (op == INSTR_LOAD) || (op == INSTR_STORE);

  // Access must land on a multiple of its own size
  always_comb begin
    case (size)
      WORD:    ldst_off = addr[1:0] != 2'b00;
      HALF:    ldst_off = addr[0];
      default: ldst_off = 1'b0;
    endcase
  end

  // Jump targets need word alignment, no compressed support
  assign misaligned_jmp  = catch_jmp & is_jmp & (addr[1:0] != 2'b00);
  assign misaligned_ldst = catch_ldst & is_ldst & ldst_off;

endmodule

// ==== source/kronos_data_mem.sv ====
// Internal word memory with byte lanes and a registered load path
// No reset on the array, the address wraps at the memory size
`timescale 1ns/1ns

`include "kronos_lsu_cfg.svh"

module kronos_data_mem (
  input  logic                clk,
  input  logic                mem_we,
  input  logic                mem_re,
  input  logic [31:0]         mem_addr,
  input  kronos_types::size_e mem_size,
  input  logic                mem_unsigned,
  input  logic [31:0]         mem_wdata,
  output logic [31:0]         mem_rdata
);

  import kronos_types::*;

  localparam int AW = $clog2(`LSU_MEM_WORDS);

  logic [31:0] mem [`LSU_MEM_WORDS];

  logic [AW-1:0] idx;
  logic [1:0]    lane;
  logic [3:0]    be;
  logic [31:0]   wdata_rep;
  logic [31:0]   rd_shift;
  logic [31:0]   rd_ext;

  // Word index from the bits above the byte offset
  assign idx = mem_addr[AW+1:2];

  // ==================================================
  // Lane select
  // ==================================================

  // Offset rounded down to the access size, replicated store data
  always_comb begin
    case (mem_size)
      BYTE: begin
        lane      = mem_addr[1:0];
        be        = 4'b0001 << lane;
        wdata_rep = {4{mem_wdata[7:0]}};
      end
      HALF: begin
        lane      = {mem_addr[1], 1'b0};
        be        = 4'b0011 << lane;
        wdata_rep = {2{mem_wdata[15:0]}};
      end
      default: begin
        lane      = 2'b00;
        be        = 4'b1111;
        wdata_rep = mem_wdata;
      end
    endcase
  end

  // ==================================================
  // Write port
  // ==================================================

  always_ff @(posedge clk) begin
    if (mem_we) begin
      for (int i = 0; i < 4; i++) begin
        if (be[i]) mem[idx][8*i +: 8] <= wdata_rep[8*i +: 8];
      end
    end
  end

  // ==================================================
  // Read path
  // ==================================================

  // Selected lane moved down to bit 0
  assign rd_shift = mem[idx] >> {lane, 3'b000};

  always_comb begin
    case (mem_size)
      BYTE:    rd_ext = {{24{~mem_unsigned & rd_shift[7]}}, rd_shift[7:0]};
      HALF:    rd_ext = {{16{~mem_unsigned & rd_shift[15]}}, rd_shift[15:0]};
      default: rd_ext = rd_shift;
    endcase
  end

  // Held until the next read strobe
  always_ff @(posedge clk) begin
    if (mem_re) mem_rdata <= rd_ext;
  end

endmodule

// ==== source/kronos_imm_decode.sv ====
// Immediate decoder for the memory and control-flow formats
// Opcodes outside S, B and J fall back to the I layout
`timescale 1ns/1ns

module kronos_imm_decode (
  input  logic [31:0] instr,
  output logic [31:0] imm
);

  import kronos_types::*;

  opcode_e op;
  logic    sign;

  // Major opcode and the common sign bit
  assign op   = opcode_e'(instr[6:2]);
  assign sign = instr[31];

  // ==================================================
  // Format select
  // ==================================================

  always_comb begin
    case (op)
      // S type, split across funct7 and rd fields
      INSTR_STORE: begin
        imm = {{20{sign}}, instr[31:25], instr[11:7]};
      end

      // B type, halfword granular, bit 0 always zero
      INSTR_BR: begin
        imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
      end

      // J type, 21 bit range
      INSTR_JAL: begin
        imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
      end

      // I type covers loads, JALR and everything else
      default: begin
        imm = {{20{sign}}, instr[31:20]};
      end
    endcase
  end

endmodule

// ==== source/kronos_lsu_cfg.svh ====
// Build constants for the load/store subsystem
// Memory depth must be a power of two, since higher address bits alias
`ifndef KRONOS_LSU_CFG_SVH
`define KRONOS_LSU_CFG_SVH

// ==================================================
// Data memory
// ==================================================

// Depth in 32-bit words
`define LSU_MEM_WORDS 256

// ==================================================
// Configuration register map
// ==================================================

`define LSU_REG_CTRL  2'd0
`define LSU_REG_CAUSE 2'd1
`define LSU_REG_TVAL  2'd2
`define LSU_REG_COUNT 2'd3

// Bit 0 jump catch, bit 1 load/store catch
`define LSU_CTRL_RESET 2'b11

`endif

// ==== source/kronos_lsu_ctrl.sv ====
// Operation controller with a fixed two cycle latency from req to ack
// Op inputs must stay stable while op_req is high
`timescale 1ns/1ns

module kronos_lsu_ctrl (
  input  logic                clk,
  input  logic                rst,
  input  logic                op_req,
  input  logic [31:0]         op_instr,
  input  logic [31:0]         op_data,
  input  logic [31:0]         addr,
  input  logic                misaligned_jmp,
  input  logic                misaligned_ldst,
  output logic                op_ack,
  output logic [31:0]         op_result,
  output logic                op_trap,
  output logic [3:0]          op_cause,
  output logic                mem_we,
  output logic                mem_re,
  output logic [31:0]         mem_addr,
  output kronos_types::size_e mem_size,
  output logic                mem_unsigned,
  output logic [31:0]         mem_wdata,
  input  logic [31:0]         mem_rdata,
  output logic                trap_valid,
  output logic [3:0]          trap_cause,
  output logic [31:0]         trap_tval
);

  import kronos_types::*;

  lsu_state_e  state, state_nxt;
  opcode_e     op;
  logic        trap_d, trap_q;
  trap_cause_e cause_d, cause_q;

  // Latched in EXEC
  logic        is_load_q, is_store_q;
  logic [31:0] addr_q, wdata_q;
  size_e       size_q;
  logic        unsigned_q;

  assign op = opcode_e'(op_instr[6:2]);

  // ==================================================
  // Trap decision
  // ==================================================

  always_comb begin
    trap_d  = 1'b0;
    cause_d = CAUSE_ILLEGAL;
    case (op)
      INSTR_LOAD: begin
        trap_d  = misaligned_ldst;
        cause_d = CAUSE_LOAD_MISALIGNED;
      end
      INSTR_STORE: begin
        trap_d  = misaligned_ldst;
        cause_d = CAUSE_STORE_MISALIGNED;
      end
      INSTR_BR, INSTR_JAL, INSTR_JALR: begin
        trap_d  = misaligned_jmp;
        cause_d = CAUSE_INSTR_MISALIGNED;
      end
      // Anything else is not handled by this stage
      default: trap_d = 1'b1;
    endcase
  end

  // ==================================================
  // FSM
  // ==================================================

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:    if (op_req) state_nxt = EXEC;
      EXEC:    state_nxt = MEM;
      MEM:     state_nxt = DONE;
      // Hold results until the master lets go
      DONE:    if (!op_req) state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= IDLE;
      trap_q <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state == EXEC) trap_q <= trap_d;
    end
  end

  always_ff @(posedge clk) begin
    if (state == EXEC) begin
      cause_q    <= cause_d;
      addr_q     <= addr;
      wdata_q    <= op_data;
      is_load_q  <= op == INSTR_LOAD;
      is_store_q <= op == INSTR_STORE;
      size_q     <= size_e'(op_instr[13:12]);
      unsigned_q <= op_instr[14];
    end
  end

  // ==================================================
  // Memory strobes only in MEM and never on a trap
  // ==================================================

  assign mem_we       = (state == MEM) & is_store_q & ~trap_q;
  assign mem_re       = (state == MEM) & is_load_q & ~trap_q;
  assign mem_addr     = addr_q;
  assign mem_size     = size_q;
  assign mem_unsigned = unsigned_q;
  assign mem_wdata    = wdata_q;

  // Status update lands before op_ack rises
  assign trap_valid = (state == MEM) & trap_q;
  assign trap_cause = cause_q;
  assign trap_tval  = addr_q;

  // ==================================================
  // Result port
  // ==================================================

  assign op_ack    = state == DONE;
  assign op_trap   = (state == DONE) & trap_q;
  assign op_cause  = cause_q;
  // Trapped loads report the address instead of stale read data
  assign op_result = (is_load_q & ~trap_q) ? mem_rdata : addr_q;

endmodule

// ==== source/kronos_lsu_regs.sv ====
// Control and trap status registers on the configuration handshake
// CAUSE and TVAL are read-only, any write to COUNT clears it
`timescale 1ns/1ns

`include "kronos_lsu_cfg.svh"

module kronos_lsu_regs (
  input  logic        clk,
  input  logic        rst,
  input  logic        cfg_req,
  input  logic        cfg_write,
  input  logic [1:0]  cfg_addr,
  input  logic [31:0] cfg_wdata,
  output logic        cfg_ack,
  output logic [31:0] cfg_rdata,
  input  logic        trap_valid,
  input  logic [3:0]  trap_cause,
  input  logic [31:0] trap_tval,
  output logic        catch_jmp,
  output logic        catch_ldst
);

  logic [1:0]  ctrl_q;
  logic [3:0]  cause_q;
  logic [31:0] tval_q;
  logic [31:0] count_q;
  logic        access;
  logic        wr_ctrl;
  logic        clr_count;

  // One access per rising req, ack follows req by one edge
  assign access    = cfg_req & ~cfg_ack;
  assign wr_ctrl   = access & cfg_write & (cfg_addr == `LSU_REG_CTRL);
  assign clr_count = access & cfg_write & (cfg_addr == `LSU_REG_COUNT);

  // ==================================================
  // Handshake and registers
  // ==================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      cfg_ack <= 1'b0;
      ctrl_q  <= `LSU_CTRL_RESET;
      cause_q <= '0;
      tval_q  <= '0;
      count_q <= '0;
    end else begin
      cfg_ack <= cfg_req;
      if (wr_ctrl) ctrl_q <= cfg_wdata[1:0];
      if (trap_valid) begin
        cause_q <= trap_cause;
        tval_q  <= trap_tval;
      end
      // A trap on the clearing edge still counts once
      if (clr_count) count_q <= {31'b0, trap_valid};
      else if (trap_valid) count_q <= count_q + 32'd1;
    end
  end

  // Read data captured on the edge that raises ack
  always_ff @(posedge clk) begin
    if (access) begin
      case (cfg_addr)
        `LSU_REG_CTRL:  cfg_rdata <= {30'b0, ctrl_q};
        `LSU_REG_CAUSE: cfg_rdata <= {28'b0, cause_q};
        `LSU_REG_TVAL:  cfg_rdata <= tval_q;
        default:        cfg_rdata <= count_q;
      endcase
    end
  end

  assign catch_jmp  = ctrl_q[0];
  assign catch_ldst = ctrl_q[1];

endmodule

// ==== source/kronos_lsu_top.sv ====
// Load/store and address stage with one operation in flight at a time
// Both ports are four-phase req/ack and the memory is internal only
`timescale 1ns/1ns

module kronos_lsu_top (
  input  logic        clk,
  input  logic        rst,
  // Operation port
  input  logic        op_req,
  input  logic [31:0] op_instr,
  input  logic [31:0] op_base,
  input  logic [31:0] op_data,
  output logic        op_ack,
  output logic [31:0] op_result,
  output logic        op_trap,
  output logic [3:0]  op_cause,
  // Configuration port
  input  logic        cfg_req,
  input  logic        cfg_write,
  input  logic [1:0]  cfg_addr,
  input  logic [31:0] cfg_wdata,
  output logic        cfg_ack,
  output logic [31:0] cfg_rdata
);

  import kronos_types::*;

  logic [31:0] imm;
  logic [31:0] addr;
  logic        misaligned_jmp, misaligned_ldst;
  logic        catch_jmp, catch_ldst;

  logic        mem_we, mem_re, mem_unsigned;
  logic [31:0] mem_addr, mem_wdata, mem_rdata;
  size_e       mem_size;

  logic        trap_valid;
  logic [3:0]  trap_cause;
  logic [31:0] trap_tval;

  // ==================================================
  // Address generation
  // ==================================================

  kronos_imm_decode u_imm (.instr(op_instr), .imm(imm));

  kronos_agu u_agu (
    .instr(op_instr), .base(op_base), .offset(imm),
    .catch_jmp(catch_jmp), .catch_ldst(catch_ldst),
    .addr(addr), .misaligned_jmp(misaligned_jmp), .misaligned_ldst(misaligned_ldst)
  );

  // ==================================================
  // Control, memory and registers
  // ==================================================

  kronos_lsu_ctrl u_ctrl (
    .clk(clk), .rst(rst),
    .op_req(op_req), .op_instr(op_instr), .op_data(op_data),
    .addr(addr), .misaligned_jmp(misaligned_jmp), .misaligned_ldst(misaligned_ldst),
    .op_ack(op_ack), .op_result(op_result), .op_trap(op_trap), .op_cause(op_cause),
    .mem_we(mem_we), .mem_re(mem_re), .mem_addr(mem_addr), .mem_size(mem_size),
    .mem_unsigned(mem_unsigned), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
    .trap_valid(trap_valid), .trap_cause(trap_cause), .trap_tval(trap_tval)
  );

  kronos_data_mem u_mem (
    .clk(clk), .mem_we(mem_we), .mem_re(mem_re), .mem_addr(mem_addr),
    .mem_size(mem_size), .mem_unsigned(mem_unsigned),
    .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
  );

  kronos_lsu_regs u_regs (
    .clk(clk), .rst(rst),
    .cfg_req(cfg_req), .cfg_write(cfg_write), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
    .cfg_ack(cfg_ack), .cfg_rdata(cfg_rdata),
    .trap_valid(trap_valid), .trap_cause(trap_cause), .trap_tval(trap_tval),
    .catch_jmp(catch_jmp), .catch_ldst(catch_ldst)
  );

endmodule

// ==== source/kronos_types.sv ====
// Shared types for the load/store and address stage
// Opcode values are RV32I bits 6:2, with only the memory and control-flow ones listed
package kronos_types;

  // ==================================================
  // Instruction fields
  // ==================================================

  // Major opcode, instr[6:2]
  typedef enum logic [4:0] {
    INSTR_LOAD  = 5'b00000,
    INSTR_STORE = 5'b01000,
    INSTR_BR    = 5'b11000,
    INSTR_JALR  = 5'b11001,
    INSTR_JAL   = 5'b11011
  } opcode_e;

  // Access size, funct3 bits 13:12
  // Bit 14 carries the unsigned flag for loads
  typedef enum logic [1:0] {
    BYTE = 2'b00,
    HALF = 2'b01,
    WORD = 2'b10
  } size_e;

  // ==================================================
  // Trap reporting
  // ==================================================

  // RISC-V mcause exception codes
  typedef enum logic [3:0] {
    CAUSE_INSTR_MISALIGNED = 4'd0,
    CAUSE_ILLEGAL          = 4'd2,
    CAUSE_LOAD_MISALIGNED  = 4'd4,
    CAUSE_STORE_MISALIGNED = 4'd6
  } trap_cause_e;

  // ==================================================
  // Controller sequencing
  // ==================================================

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    EXEC = 2'd1,
    MEM  = 2'd2,
    DONE = 2'd3
  } lsu_state_e;

endpackage

// ==== testbench/kronos_lsu_tb.sv ====
// Self-checking testbench for the load/store and address stage
// Memory traffic stays in a 64-byte window that is written before any load reads it
`timescale 1ns/1ns

`include "kronos_lsu_cfg.svh"

module kronos_lsu_tb;

  import kronos_types::*;

  localparam int RESET_CYCLES = 8;
  localparam int MEM_BYTES    = `LSU_MEM_WORDS * 4;
  localparam int WIN_WORDS    = 16;

  logic        clk;
  logic        rst;
  logic        op_req;
  logic [31:0] op_instr;
  logic [31:0] op_base;
  logic [31:0] op_data;
  logic        op_ack;
  logic [31:0] op_result;
  logic        op_trap;
  logic [3:0]  op_cause;
  logic        cfg_req;
  logic        cfg_write;
  logic [1:0]  cfg_addr;
  logic [31:0] cfg_wdata;
  logic        cfg_ack;
  logic [31:0] cfg_rdata;

  // Expected response of the transfer in flight
  logic [31:0] exp_result;
  logic        exp_trap;
  logic [3:0]  exp_cause;
  logic        cfg_check;
  logic [31:0] exp_cfg;

  // Shadow copy of CTRL and of the trap status registers
  logic        catch_jmp_en;
  logic        catch_ldst_en;
  logic [3:0]  last_cause;
  logic [31:0] last_tval;
  int          trap_total;

  logic [7:0]  ref_mem [MEM_BYTES];
  logic [31:0] lfsr;
  int          hold_bits;
  int          ops_issued;
  int          cycles;
  int          errors;
  int          err_mark;

  kronos_lsu_top kronos_lsu_top_inst (
    .clk(clk), .rst(rst),
    .op_req(op_req), .op_instr(op_instr), .op_base(op_base), .op_data(op_data),
    .op_ack(op_ack), .op_result(op_result), .op_trap(op_trap), .op_cause(op_cause),
    .cfg_req(cfg_req), .cfg_write(cfg_write), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
    .cfg_ack(cfg_ack), .cfg_rdata(cfg_rdata)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // Budget of 40 cycles per transfer issued so far on top of reset
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > 40 * (ops_issued + 1) + RESET_CYCLES) begin
      $display("timeout: handshake did not complete within %0d cycles", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // ==================================================
  // Checkers
  // ==================================================

  a_reset: assert property (@(posedge clk)
    rst |=> !op_ack && !cfg_ack && !op_trap && !kronos_lsu_top_inst.u_ctrl.trap_valid)
    else begin
      $display("ack, trap or trap_valid not low after reset");
      errors++;
    end

  // Ack rises on the second edge after the one that samples req
  a_op_latency: assert property (@(posedge clk) disable iff (rst)
    $rose(op_ack) |-> $past(op_req, 3) && !$past(op_req, 4))
    else begin
      $display("op_ack rose at the wrong distance from op_req");
      errors++;
    end

  a_op_release: assert property (@(posedge clk) disable iff (rst)
    $fell(op_req) |=> $fell(op_ack))
    else begin
      $display("op_ack did not fall one edge after op_req dropped");
      errors++;
    end

  // Results frozen while the master holds req
  a_op_hold: assert property (@(posedge clk) disable iff (rst)
    op_ack && op_req |=> op_ack && $stable(op_result) && $stable(op_trap))
    else begin
      $display("op_ack or the results changed while op_req was held");
      errors++;
    end

  a_result: assert property (@(posedge clk) disable iff (rst)
    $rose(op_ack) |-> op_result == exp_result)
    else begin
      $display("mismatch op_result: got %h expected %h", op_result, exp_result);
      errors++;
    end

  a_trap: assert property (@(posedge clk) disable iff (rst)
    $rose(op_ack) |-> op_trap == exp_trap)
    else begin
      $display("mismatch op_trap: got %h expected %h", op_trap, exp_trap);
      errors++;
    end

  a_cause: assert property (@(posedge clk) disable iff (rst)
    $rose(op_ack) && exp_trap |-> op_cause == exp_cause)
    else begin
      $display("mismatch op_cause: got %h expected %h", op_cause, exp_cause);
      errors++;
    end

  a_cfg_latency: assert property (@(posedge clk) disable iff (rst)
    $rose(cfg_ack) |-> $past(cfg_req) && !$past(cfg_req, 2))
    else begin
      $display("cfg_ack rose at the wrong distance from cfg_req");
      errors++;
    end

  a_cfg_release: assert property (@(posedge clk) disable iff (rst)
    $fell(cfg_req) |=> $fell(cfg_ack))
    else begin
      $display("cfg_ack did not fall one edge after cfg_req dropped");
      errors++;
    end

  a_cfg_rdata: assert property (@(posedge clk) disable iff (rst)
    $rose(cfg_ack) && cfg_check |-> cfg_rdata == exp_cfg)
    else begin
      $display("mismatch cfg_rdata: got %h expected %h", cfg_rdata, exp_cfg);
      errors++;
    end

  // ==================================================
  // Random source and reference memory
  // ==================================================

  // Galois form of x^32+x^22+x^2+x+1 with one step per bit
  function automatic logic [31:0] lfsr_take(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
    end
    return v;
  endfunction

  // Byte offset in memory rounded down to the access size
  function automatic int byte_index(input logic [31:0] addr, input logic [1:0] sz);
    int a;
    a = int'(addr & (MEM_BYTES - 1));
    return a & ~((1 << sz) - 1);
  endfunction

  function automatic void ref_store(input logic [31:0] addr, input logic [1:0] sz,
                                    input logic [31:0] data);
    int a;
    a = byte_index(addr, sz);
    for (int i = 0; i < (1 << sz); i++) ref_mem[a + i] = data[8*i +: 8];
  endfunction

  function automatic logic [31:0] ref_load(input logic [31:0] addr, input logic [1:0] sz,
                                           input logic uns);
    int          a;
    logic [31:0] w;
    a = byte_index(addr, sz);
    case (sz)
      2'b00:   w = {{24{~uns & ref_mem[a][7]}}, ref_mem[a]};
      2'b01:   w = {{16{~uns & ref_mem[a+1][7]}}, ref_mem[a+1], ref_mem[a]};
      default: w = {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
    endcase
    return w;
  endfunction

  // Size-aligned byte address inside the window
  function automatic logic [31:0] win_addr(input logic [1:0] sz);
    return lfsr_take(6) & ~((32'd1 << sz) - 32'd1);
  endfunction

  // ==================================================
  // Bus drivers
  // ==================================================

  task automatic issue_op(input logic [31:0] instr, input logic [31:0] base,
                          input logic [31:0] data);
    int hold;
    hold = int'(lfsr_take(hold_bits));
    ops_issued++;
    repeat (int'(lfsr_take(hold_bits))) @(posedge clk);
    @(posedge clk);
    op_instr <= instr;
    op_base  <= base;
    op_data  <= data;
    op_req   <= 1'b1;
    @(posedge clk);
    while (!op_ack) @(posedge clk);
    repeat (hold) @(posedge clk);
    op_req <= 1'b0;
    @(posedge clk);
    while (op_ack) @(posedge clk);
  endtask

  task automatic cfg_access(input logic wr, input logic [1:0] addr,
                            input logic [31:0] wdata, input logic [31:0] rd_expect);
    ops_issued++;
    cfg_check = !wr;
    exp_cfg   = rd_expect;
    @(posedge clk);
    cfg_req   <= 1'b1;
    cfg_write <= wr;
    cfg_addr  <= addr;
    cfg_wdata <= wdata;
    @(posedge clk);
    while (!cfg_ack) @(posedge clk);
    cfg_req <= 1'b0;
    @(posedge clk);
    while (cfg_ack) @(posedge clk);
  endtask

  task automatic note_trap(input logic [3:0] cause, input logic [31:0] tval);
    trap_total++;
    last_cause = cause;
    last_tval  = tval;
  endtask

  // ==================================================
  // Operation builders
  // ==================================================

  // Target low bits come from the window and the high bits alias at random
  task automatic mem_op(input logic is_store, input logic [2:0] funct3,
                        input logic [31:0] target);
    logic [31:0] imm, addr, base, data, instr;
    logic        mis;
    imm  = lfsr_take(12);
    imm  = {{20{imm[11]}}, imm[11:0]};
    addr = target + (lfsr_take(22) << 10);
    base = addr - imm;
    data = lfsr_take(32);
    mis  = (funct3[1:0] == 2'b10 && addr[1:0] != 2'b00) || (funct3[1:0] == 2'b01 && addr[0]);
    if (is_store) instr = {imm[11:5], 5'd3, 5'd2, funct3, imm[4:0], 7'b0100011};
    else instr = {imm[11:0], 5'd2, funct3, 5'd1, 7'b0000011};
    exp_trap   = mis && catch_ldst_en;
    exp_cause  = is_store ? CAUSE_STORE_MISALIGNED : CAUSE_LOAD_MISALIGNED;
    exp_result = addr;
    if (exp_trap) note_trap(exp_cause, addr);
    else if (is_store) ref_store(addr, funct3[1:0], data);
    else exp_result = ref_load(addr, funct3[1:0], funct3[2]);
    issue_op(instr, base, data);
  endtask

  // Kind is 0 for JAL, 1 for JALR and 2 for a branch
  // Low sets bits 1:0 of the sum
  task automatic jump_op(input int kind, input logic [1:0] low);
    logic [31:0] imm, base, target, instr;
    if (kind == 0) imm = lfsr_take(20) << 1;
    else if (kind == 1) imm = lfsr_take(12);
    else imm = lfsr_take(12) << 1;
    if (kind == 0) imm = {{11{imm[20]}}, imm[20:0]};
    else if (kind == 1) imm = {{20{imm[11]}}, imm[11:0]};
    else imm = {{19{imm[12]}}, imm[12:0]};
    base      = lfsr_take(32);
    base[1:0] = low - imm[1:0];
    target    = base + imm;
    if (kind == 1) target[0] = 1'b0;
    case (kind)
      0: instr = {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
      1: instr = {imm[11:0], 5'd2, 3'b000, 5'd1, 7'b1100111};
      default: instr = {imm[12], imm[10:5], 5'd3, 5'd2, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endcase
    exp_result = target;
    exp_trap   = catch_jmp_en && target[1:0] != 2'b00;
    exp_cause  = CAUSE_INSTR_MISALIGNED;
    if (exp_trap) note_trap(exp_cause, target);
    issue_op(instr, base, 32'h0);
  endtask

  // OP and OP-IMM major opcodes are outside this stage
  task automatic illegal_op();
    logic [31:0] imm, base;
    logic [6:0]  opc;
    imm        = lfsr_take(12);
    imm        = {{20{imm[11]}}, imm[11:0]};
    base       = lfsr_take(32);
    opc        = lfsr_take(1) ? 7'b0110011 : 7'b0010011;
    exp_result = base + imm;
    exp_trap   = 1'b1;
    exp_cause  = CAUSE_ILLEGAL;
    note_trap(exp_cause, exp_result);
    issue_op({imm[11:0], 5'd2, 3'b000, 5'd1, opc}, base, 32'h0);
  endtask

  task automatic random_mem_op();
    logic [2:0] kind;
    logic [2:0] f3;
    kind = 3'(lfsr_take(3));
    case (kind)
      3'd0, 3'd3: f3 = 3'b010;
      3'd1, 3'd4: f3 = 3'b001;
      3'd5:       f3 = 3'b101;
      3'd7:       f3 = 3'b100;
      default:    f3 = 3'b000;
    endcase
    mem_op(kind < 3'd3, f3, win_addr(f3[1:0]));
  endtask

  task automatic check_status();
    cfg_access(1'b0, `LSU_REG_CAUSE, 32'h0, {28'h0, last_cause});
    cfg_access(1'b0, `LSU_REG_TVAL, 32'h0, last_tval);
  endtask

  task automatic finish_test(input int n, input string name);
    $display("test %0d %s: %0d errors", n, name, errors - err_mark);
    err_mark = errors;
  endtask

  // ==================================================
  // Test sequence
  // ==================================================

  initial begin
    logic [31:0] t;
    lfsr       = 32'hc6079ed2;
    rst        = 1'b1;
    op_req     = 1'b0;
    op_instr   = 32'h0;
    op_base    = 32'h0;
    op_data    = 32'h0;
    cfg_req    = 1'b0;
    cfg_write  = 1'b0;
    cfg_addr   = 2'b00;
    cfg_wdata  = 32'h0;
    exp_result = 32'h0;
    exp_trap   = 1'b0;
    exp_cause  = 4'h0;
    cfg_check  = 1'b0;
    exp_cfg    = 32'h0;
    last_cause = 4'h0;
    last_tval  = 32'h0;
    trap_total = 0;
    hold_bits  = 1;
    ops_issued = 0;
    cycles     = 0;
    errors     = 0;
    err_mark   = 0;
    {catch_ldst_en, catch_jmp_en} = `LSU_CTRL_RESET;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;

    // Fill the window before mixed aligned traffic
    for (int i = 0; i < WIN_WORDS; i++) mem_op(1'b1, 3'b010, 32'(i * 4));
    repeat (40) random_mem_op();
    finish_test(1, "store/load round trip");

    repeat (30) jump_op(int'(lfsr_take(2) % 3), 2'(lfsr_take(2)));
    finish_test(2, "address generation");

    // COUNT restarts from zero for the trap checks
    cfg_access(1'b1, `LSU_REG_COUNT, 32'hffffffff, 32'h0);
    trap_total = 0;
    cfg_access(1'b0, `LSU_REG_COUNT, 32'h0, 32'h0);
    for (int i = 0; i < 4; i++) begin
      t = win_addr(2'b10) + 32'd1 + (lfsr_take(2) % 3);
      mem_op(1'b0, 3'b010, t);
      check_status();
      mem_op(1'b1, 3'b010, t);
      check_status();
      mem_op(1'b0, 3'b010, t & ~32'd3);
      t = win_addr(2'b01) + 32'd1;
      mem_op(1'b0, 3'b001, t);
      mem_op(1'b1, 3'b001, t);
      check_status();
      mem_op(1'b0, 3'b010, t & ~32'd3);
      jump_op(i % 3, 2'b10);
      check_status();
      illegal_op();
      check_status();
    end
    cfg_access(1'b0, `LSU_REG_COUNT, 32'h0, 32'(trap_total));
    finish_test(3, "traps with catches enabled");

    cfg_access(1'b1, `LSU_REG_CTRL, 32'h0, 32'h0);
    {catch_ldst_en, catch_jmp_en} = 2'b00;
    cfg_access(1'b0, `LSU_REG_CTRL, 32'h0, 32'h0);
    for (int i = 0; i < 6; i++) begin
      mem_op(1'b1, 3'b010, win_addr(2'b10) + 32'd1 + (lfsr_take(2) % 3));
      mem_op(1'b1, 3'b001, win_addr(2'b01) + 32'd1);
      mem_op(1'b0, 3'b010, win_addr(2'b10) + 32'd1 + (lfsr_take(2) % 3));
      mem_op(1'b0, {lfsr_take(1) == 32'd1, 2'b01}, win_addr(2'b01) + 32'd1);
      jump_op(i % 3, 2'b10);
    end
    cfg_access(1'b1, `LSU_REG_CTRL, 32'(`LSU_CTRL_RESET), 32'h0);
    {catch_ldst_en, catch_jmp_en} = `LSU_CTRL_RESET;
    cfg_access(1'b0, `LSU_REG_CTRL, 32'h0, 32'(`LSU_CTRL_RESET));
    finish_test(4, "catches disabled");

    // Longer random req holds and idle gaps
    hold_bits = 3;
    for (int i = 0; i < 24; i++) begin
      if (lfsr_take(1)) random_mem_op();
      else jump_op(int'(lfsr_take(2) % 3), 2'(lfsr_take(2)));
    end
    cfg_access(1'b0, `LSU_REG_COUNT, 32'h0, 32'(trap_total));
    finish_test(5, "handshake timing");

    $display("%0d transfers, %0d traps, %0d errors", ops_issued, trap_total, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
